//--- src/x86_isa_pkg.sv
// ==============================
// Instruction-encoding package
//   Field widths, register and segment codes
//   Opcode byte views and opcode union
//   ModR/M byte layout
// ==============================

package x86_isa_pkg;

    localparam int REG_ID_W = 4;    // Register code, high bit marks segment/none
    localparam int SEG_ID_W = 2;
    localparam int FIELD_W  = 3;    // reg and rm fields
    localparam int MOD_W    = 2;

    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [SEG_ID_W-1:0] seg_id_t;

    // Opcode with direction and width bits
    typedef struct packed {
        logic [5:0] op;
        logic       d;              // Set when reg field is the destination
        logic       w;              // Set for word operands
    } opcode_alu_t;

    // Opcode carrying its own register, as in MOV R IMM and XCHG ACC
    typedef struct packed {
        logic [3:0]         op;
        logic               w;      // Part of the opcode for XCHG ACC
        logic [FIELD_W-1:0] reg_f;
    } opcode_short_t;

    typedef union packed {
        opcode_alu_t   alu;
        opcode_short_t short_form;
    } opcode_u;

    typedef struct packed {
        logic [MOD_W-1:0]   mod;
        logic [FIELD_W-1:0] reg_f;
        logic [FIELD_W-1:0] rm;
    } modrm_t;

    localparam logic [MOD_W-1:0]   MOD_REG   = 2'b11;   // Register operand
    localparam logic [FIELD_W-1:0] RM_DIRECT = 3'b110;  // Direct address with mod 0

    // Register codes used in effective-address generation
    localparam reg_id_t REG_BX   = 4'd3;
    localparam reg_id_t REG_BP   = 4'd5;
    localparam reg_id_t REG_SI   = 4'd6;
    localparam reg_id_t REG_DI   = 4'd7;
    localparam reg_id_t REG_NONE = 4'd12;   // Unused base or index

    localparam seg_id_t SEG_SS = 2'd2;
    localparam seg_id_t SEG_DS = 2'd3;

endpackage

//--- src/decode_pkg.sv
// ==============================
// Decoder-result package
//   Effective-address record
//   Decoded instruction record
//   Displacement/immediate size codes
// ==============================

package decode_pkg;

    import x86_isa_pkg::*;

    // Registers and segment for the address calculation
    typedef struct packed {
        reg_id_t base;
        reg_id_t index;
        seg_id_t seg;
    } ea_t;

    // One decoded opcode/ModR/M pair
    typedef struct packed {
        logic    need_modrm;
        logic    need_disp;
        logic    disp_size;     // DISP_8 or DISP_16
        logic    need_imm;
        logic    imm_size;      // Same encoding as disp_size
        logic    word;          // Operand width, set for 16 bit
        reg_id_t src;
        reg_id_t dst;
        ea_t     ea;
    } decoded_t;

    // Size codes for displacement and immediate
    localparam logic DISP_8  = 1'b0;
    localparam logic DISP_16 = 1'b1;

endpackage

//--- src/ea_decode.sv
// ==============================
// ModR/M address decoder
//   Base, index and default segment from rm/mod
//   Displacement need and size from mod
// ==============================

`timescale 1ns/10ps

module ea_decode
    import x86_isa_pkg::*, decode_pkg::*;
(
    input  modrm_t modrm,
    output ea_t    ea,
    output logic   disp_needed,
    output logic   disp_wide
);

    logic direct;

    // mod 0 with rm 6 replaces the BP form with a 16-bit address
    assign direct = (modrm.mod == 2'b00) && (modrm.rm == RM_DIRECT);

    assign disp_needed = direct || (modrm.mod == 2'b01) || (modrm.mod == 2'b10);
    assign disp_wide   = direct || (modrm.mod == 2'b10);   // mod 1 is 8 bit

    always_comb
    begin
        case (modrm.rm)
            3'd0:
            begin
                ea = '{base: REG_BX, index: REG_SI, seg: SEG_DS};
            end
            3'd1:
            begin
                ea = '{base: REG_BX, index: REG_DI, seg: SEG_DS};
            end
            3'd2:
            begin
                ea = '{base: REG_BP, index: REG_SI, seg: SEG_SS};  // BP implies stack
            end
            3'd3:
            begin
                ea = '{base: REG_BP, index: REG_DI, seg: SEG_SS};
            end
            3'd4:
            begin
                ea = '{base: REG_NONE, index: REG_SI, seg: SEG_DS};
            end
            3'd5:
            begin
                ea = '{base: REG_NONE, index: REG_DI, seg: SEG_DS};
            end
            3'd6:
            begin
                if (direct)
                    ea = '{base: REG_NONE, index: REG_NONE, seg: SEG_DS};
                else
                    ea = '{base: REG_BP, index: REG_NONE, seg: SEG_SS};
            end
            default: // rm 7
            begin
                ea = '{base: REG_BX, index: REG_NONE, seg: SEG_DS};
            end
        endcase
    end

endmodule

//--- src/opcode_decode.sv
// ==============================
// Opcode class table
//   ModR/M, displacement and immediate needs
//   Source/destination register codes
//   Operand width bit
// ==============================

`timescale 1ns/10ps

module opcode_decode
    import x86_isa_pkg::*, decode_pkg::*;
(
    input  opcode_u  opcode,
    input  modrm_t   modrm,
    input  ea_t      ea,
    input  logic     disp_needed,
    input  logic     disp_wide,
    output decoded_t dec
);

    logic [FIELD_W-1:0] dstm;
    logic [FIELD_W-1:0] srcm;
    logic               mod_reg;
    logic               word_from_bit3;

    // D selects which ModR/M field is written
    assign dstm = opcode.alu.d ? modrm.reg_f : modrm.rm;
    assign srcm = opcode.alu.d ? modrm.rm : modrm.reg_f;

    assign mod_reg = (modrm.mod == MOD_REG);

    // MOV R IMM and 1000_11xx keep their width in bit 3
    assign word_from_bit3 = (opcode.short_form.op == 4'b1011) ||
                            (opcode.alu.op == 6'b100011);

    always_comb
    begin
        dec      = '0;      // Unlisted classes decode to nothing
        dec.ea   = ea;
        dec.word = word_from_bit3 ? opcode.short_form.w : opcode.alu.w;

        casez (opcode)
            8'b00??_?0??,   // ADD/OR/ADC/SBB/AND/SUB/XOR/CMP R/M R
            8'b1000_010?,   // TEST R/M R
            8'b1000_011?:   // XCHG R/M R
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.dst        = {1'b0, dstm};
                dec.src        = {1'b0, srcm};
            end

            8'b00??_?10?,   // ALU ACC IMM
            8'b1010_100?:   // TEST ACC IMM
            begin
                dec.need_imm = 1'b1;
                dec.imm_size = opcode.alu.w ? DISP_16 : DISP_8;
            end

            8'b0111_????: // Short conditional branch
            begin
                dec.need_disp = 1'b1;
                dec.disp_size = DISP_8;
            end

            8'b1000_00??: // Group 1 R/M IMM
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.need_imm   = 1'b1;
                // 83 sign-extends an 8-bit immediate
                dec.imm_size   = (!opcode[1] && opcode[0]) ? DISP_16 : DISP_8;
                dec.dst        = {1'b0, modrm.rm};
            end

            8'b1000_10??: // MOV R/M R
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = mod_reg ? 1'b0 : disp_needed;
                dec.disp_size  = mod_reg ? DISP_8 : disp_wide;
                dec.dst        = {1'b0, dstm};
                dec.src        = {1'b0, srcm};
            end

            8'b1000_11?0: // MOV R/M SREG and back
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = mod_reg ? 1'b0 : disp_needed;
                dec.disp_size  = mod_reg ? DISP_8 : disp_wide;
                dec.dst        = {opcode.alu.d, dstm};     // Segment side gets the high bit
                dec.src        = {~opcode.alu.d, srcm};
            end

            8'b1000_1101: // LEA, register form undefined
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.dst        = {1'b0, dstm};
            end

            8'b1000_1111: // POP R/M
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.dst        = {1'b0, modrm.rm};
            end

            8'b1001_0???: // XCHG ACC, 90 is NOP
            begin
                dec.src = {1'b0, opcode.short_form.reg_f};
            end

            8'b1001_1010: // CALL far, offset then segment
            begin
                dec.need_disp = 1'b1;
                dec.disp_size = DISP_16;
                dec.need_imm  = 1'b1;
                dec.imm_size  = DISP_16;
            end

            8'b1010_00??: // MOV M ACC
            begin
                dec.need_disp = 1'b1;
                dec.disp_size = DISP_16;   // Always a direct address
            end

            8'b1011_????: // MOV R IMM
            begin
                dec.need_imm = 1'b1;
                dec.imm_size = opcode.short_form.w ? DISP_16 : DISP_8;
                dec.dst      = {1'b0, opcode.short_form.reg_f};
            end

            8'b1100_000?: // Shift/rotate group by IMM8
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.need_imm   = 1'b1;
                dec.imm_size   = DISP_8;
                dec.dst        = {1'b0, modrm.rm};
                dec.src        = {1'b0, modrm.rm};
            end

            8'b1100_0010: // RET with pop value
            begin
                dec.need_imm = 1'b1;
                dec.imm_size = DISP_16;
            end

            8'b1100_010?: // LES/LDS
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.src        = {1'b0, srcm};
            end

            8'b1100_011?: // MOV R/M IMM
            begin
                dec.need_modrm = 1'b1;
                dec.need_disp  = disp_needed;
                dec.disp_size  = disp_wide;
                dec.need_imm   = 1'b1;
                dec.imm_size   = opcode.alu.w ? DISP_16 : DISP_8;
                dec.dst        = {1'b0, modrm.rm};
            end

            8'b1100_1000: // ENTER
            begin
                dec.need_imm = 1'b1;
                dec.imm_size = DISP_8;
            end

            default:
            begin
                dec.need_modrm = 1'b0;  // Record stays clear
            end
        endcase
    end

endmodule

//--- src/instr_decoder.sv
// ==============================
// First-byte decode stage
//   Address and opcode decoders
//   Registered decoded record
// ==============================

`timescale 1ns/10ps

module instr_decoder
    import x86_isa_pkg::*, decode_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     insn_valid,
    input  opcode_u  opcode,
    input  modrm_t   modrm,
    output logic     dec_valid,
    output decoded_t dec
);

    ea_t      ea;
    logic     disp_needed;
    logic     disp_wide;
    decoded_t dec_next;

    ea_decode i_ea
    (
        .modrm       (modrm),
        .ea          (ea),
        .disp_needed (disp_needed),
        .disp_wide   (disp_wide)
    );

    opcode_decode i_opcode
    (
        .opcode      (opcode),
        .modrm       (modrm),
        .ea          (ea),
        .disp_needed (disp_needed),
        .disp_wide   (disp_wide),
        .dec         (dec_next)
    );

    // One-cycle stage, no stall path
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end
        else
        begin
            dec_valid <= insn_valid;
            if (insn_valid)
                dec <= dec_next;    // Hold last record between strobes
        end
    end

endmodule

//--- testbench/instr_decoder_asserts.sv
// ==============================
// Bound checks on instr_decoder
//   Reset clears dec_valid
//   One-cycle valid latency
//   Record held while idle
//   Immediate size only with need_imm
// ==============================

`timescale 1ns/10ps

module instr_decoder_asserts
    import decode_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     insn_valid,
    input logic     dec_valid,
    input decoded_t dec
);

    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !dec_valid)
        else $error("dec_valid high in the cycle after reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (reset)
        insn_valid |=> dec_valid)
        else $error("dec_valid missing one cycle after insn_valid");

    a_idle_follows: assert property (@(posedge clk) disable iff (reset)
        !insn_valid |=> !dec_valid)
        else $error("dec_valid high without a strobe");

    // Record only loads on a strobe
    a_dec_held: assert property (@(posedge clk) disable iff (reset)
        !dec_valid |-> $stable(dec))
        else $error("dec changed while dec_valid low");

    a_imm_size_needs_imm: assert property (@(posedge clk) disable iff (reset)
        dec.imm_size |-> dec.need_imm)
        else $error("imm_size set without need_imm");

endmodule

bind instr_decoder instr_decoder_asserts i_asserts
(
    .clk        (clk),
    .reset      (reset),
    .insn_valid (insn_valid),
    .dec_valid  (dec_valid),
    .dec        (dec)
);

//--- testbench/tb_instr_decoder.sv
// ==============================
// Testbench for instr_decoder
//   Clock, reset and LFSR stimulus
//   Reference decode model
//   Directed tests and watchdog
// ==============================

`timescale 1ns/10ps

module tb_instr_decoder
    import x86_isa_pkg::*, decode_pkg::*;
();

    localparam int STREAM_LEN  = 200;
    localparam int NUM_VECTORS = 130 + STREAM_LEN;
    localparam int WATCHDOG_NS = NUM_VECTORS * 10 * 4;

    logic        clk;
    logic        reset;
    logic        insn_valid;
    opcode_u     opcode;
    modrm_t      modrm;
    logic        dec_valid;
    decoded_t    dec;
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    instr_decoder i_dut
    (
        .clk        (clk),
        .reset      (reset),
        .insn_valid (insn_valid),
        .opcode     (opcode),
        .modrm      (modrm),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        return s >> 1;
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic ea_t ref_ea(input modrm_t m, input logic direct);
        case (m.rm)
            3'd0: return '{base: REG_BX, index: REG_SI, seg: SEG_DS};
            3'd1: return '{base: REG_BX, index: REG_DI, seg: SEG_DS};
            3'd2: return '{base: REG_BP, index: REG_SI, seg: SEG_SS};
            3'd3: return '{base: REG_BP, index: REG_DI, seg: SEG_SS};
            3'd4: return '{base: REG_NONE, index: REG_SI, seg: SEG_DS};
            3'd5: return '{base: REG_NONE, index: REG_DI, seg: SEG_DS};
            3'd6:
            begin
                if (direct)
                    return '{base: REG_NONE, index: REG_NONE, seg: SEG_DS};
                return '{base: REG_BP, index: REG_NONE, seg: SEG_SS};
            end
            default: return '{base: REG_BX, index: REG_NONE, seg: SEG_DS};
        endcase
    endfunction

    // Expected record built from the opcode class rules
    function automatic decoded_t ref_decode(input logic [7:0] op, input modrm_t m);
        decoded_t   r;
        logic       direct;
        logic       uses_modrm;
        logic [2:0] to_f;
        logic [2:0] from_f;
        r          = '0;
        uses_modrm = 1'b0;
        direct     = (m.mod == 2'd0) && (m.rm == 3'd6);
        to_f       = op[1] ? m.reg_f : m.rm;     // D bit picks the destination
        from_f     = op[1] ? m.rm : m.reg_f;
        r.ea       = ref_ea(m, direct);
        r.word     = (op[7:4] == 4'hb || op[7:2] == 6'b100011) ? op[3] : op[0];
        casez (op)
            8'b00??_?0??, 8'b1000_01??, 8'b1000_10??:
            begin
                uses_modrm = 1'b1;
                r.dst      = {1'b0, to_f};
                r.src      = {1'b0, from_f};
            end
            8'b00??_?10?, 8'b1010_100?:
            begin
                r.need_imm = 1'b1;
                r.imm_size = op[0];
            end
            8'b0111_????: r.need_disp = 1'b1;   // 8-bit branch offset
            8'b1000_00??:
            begin
                uses_modrm = 1'b1;
                r.need_imm = 1'b1;
                r.imm_size = (op[1:0] == 2'b01);
                r.dst      = {1'b0, m.rm};
            end
            8'b1000_11?0:
            begin
                uses_modrm = 1'b1;
                // reg field names the segment register
                if (op[1])
                begin
                    r.dst = {1'b1, m.reg_f};
                    r.src = {1'b0, m.rm};
                end
                else
                begin
                    r.dst = {1'b0, m.rm};
                    r.src = {1'b1, m.reg_f};
                end
            end
            8'b1000_1101:
            begin
                uses_modrm = 1'b1;
                r.dst      = {1'b0, to_f};
            end
            8'b1000_1111:
            begin
                uses_modrm = 1'b1;
                r.dst      = {1'b0, m.rm};
            end
            8'b1001_0???: r.src = {1'b0, op[2:0]};
            8'b1001_1010:
            begin
                r.need_disp = 1'b1;
                r.disp_size = DISP_16;
                r.need_imm  = 1'b1;
                r.imm_size  = DISP_16;
            end
            8'b1010_00??:
            begin
                r.need_disp = 1'b1;
                r.disp_size = DISP_16;
            end
            8'b1011_????:
            begin
                r.need_imm = 1'b1;
                r.imm_size = op[3];
                r.dst      = {1'b0, op[2:0]};
            end
            8'b1100_000?:
            begin
                uses_modrm = 1'b1;
                r.need_imm = 1'b1;
                r.dst      = {1'b0, m.rm};
                r.src      = {1'b0, m.rm};
            end
            8'b1100_0010:
            begin
                r.need_imm = 1'b1;
                r.imm_size = DISP_16;
            end
            8'b1100_010?:
            begin
                uses_modrm = 1'b1;
                r.src      = {1'b0, from_f};
            end
            8'b1100_011?:
            begin
                uses_modrm = 1'b1;
                r.need_imm = 1'b1;
                r.imm_size = op[0];
                r.dst      = {1'b0, m.rm};
            end
            8'b1100_1000: r.need_imm = 1'b1;    // ENTER
            default: ;
        endcase
        if (uses_modrm)
        begin
            r.need_modrm = 1'b1;
            r.need_disp  = direct || (m.mod == 2'd1) || (m.mod == 2'd2);
            r.disp_size  = direct || (m.mod == 2'd2);
        end
        return r;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_decode(input logic [7:0] op, input modrm_t m);
        decoded_t exp;
        exp = ref_decode(op, m);
        check_bit("dec.need_modrm", dec.need_modrm, exp.need_modrm);
        check_bit("dec.need_disp", dec.need_disp, exp.need_disp);
        check_bit("dec.disp_size", dec.disp_size, exp.disp_size);
        check_bit("dec.need_imm", dec.need_imm, exp.need_imm);
        check_bit("dec.imm_size", dec.imm_size, exp.imm_size);
        check_bit("dec.word", dec.word, exp.word);
        check_code("dec.src", dec.src, exp.src);
        check_code("dec.dst", dec.dst, exp.dst);
        check_code("dec.ea.base", dec.ea.base, exp.ea.base);
        check_code("dec.ea.index", dec.ea.index, exp.ea.index);
        check_code("dec.ea.seg", {2'b00, dec.ea.seg}, {2'b00, exp.ea.seg});
    endtask

    // One strobe, then the result one cycle later
    task automatic apply_pair(input logic [7:0] op, input modrm_t m);
        @(negedge clk);
        insn_valid = 1'b1;
        opcode     = op;
        modrm      = m;
        @(negedge clk);
        insn_valid = 1'b0;
        check_bit("dec_valid", dec_valid, 1'b1);
        expect_decode(op, m);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_bit("dec_valid", dec_valid, 1'b0);
            checks++;
            if (dec !== '0)
            begin
                errors++;
                $display("ERROR at %0t: dec = %h, expected 000000", $time, dec);
            end
        end
    endtask

    task automatic test_alu_regs();
        for (int a = 0; a < 8; a++)
            for (int d = 0; d < 2; d++)
                for (int w = 0; w < 2; w++)
                    apply_pair({2'b00, a[2:0], 1'b0, d[0], w[0]},
                               {MOD_REG, a[2:0], 3'd7 - a[2:0]});
    endtask

    task automatic test_ea_modes();
        for (int md = 0; md < 4; md++)
            for (int rm = 0; rm < 8; rm++)
                apply_pair(8'h00, {md[1:0], 3'd2, rm[2:0]});    // ADD R/M R
    endtask

    task automatic test_immediates();
        for (int a = 0; a < 8; a++)
            for (int w = 0; w < 2; w++)
                apply_pair({2'b00, a[2:0], 2'b10, w[0]}, 8'h00);
        apply_pair(8'ha8, 8'h00);
        apply_pair(8'ha9, 8'h00);
        for (int i = 0; i < 16; i++)
            apply_pair(8'hb0 + 8'(i), 8'h00);
        for (int i = 0; i < 4; i++)
            apply_pair(8'h80 + 8'(i), {2'b01, 3'd0, 3'd3});
        apply_pair(8'hc2, 8'h00);
        apply_pair(8'h9a, 8'h00);
    endtask

    task automatic test_special();
        apply_pair(8'h8c, {MOD_REG, 3'd3, 3'd1});   // Segment to register
        apply_pair(8'h8e, {MOD_REG, 3'd3, 3'd1});
        apply_pair(8'h8c, {2'b10, 3'd2, 3'd4});
        apply_pair(8'h88, {MOD_REG, 3'd5, 3'd2});
        apply_pair(8'h8b, {MOD_REG, 3'd1, 3'd6});
        apply_pair(8'h89, {2'b00, 3'd0, 3'd6});
        for (int i = 0; i < 8; i++)
            apply_pair(8'h90 + 8'(i), 8'h00);
        apply_pair(8'ha4, {2'b01, 3'd0, 3'd0});     // String ops decode to nothing
        apply_pair(8'ha5, 8'h00);
        apply_pair(8'h26, 8'h00);
        apply_pair(8'h40, 8'h00);
        apply_pair(8'h74, 8'h00);
        apply_pair(8'hc8, 8'h00);
        apply_pair(8'hc7, {2'b10, 3'd0, 3'd1});
        apply_pair(8'ha1, 8'h00);
    endtask

    task automatic check_prev(input logic had, input logic [7:0] op, input modrm_t m);
        check_bit("dec_valid", dec_valid, had);
        if (had)
            expect_decode(op, m);
    endtask

    task automatic test_stream();
        logic [31:0] r;
        logic [7:0]  op;
        modrm_t      m;
        logic        had;
        logic [7:0]  last_op;
        modrm_t      last_m;
        had     = 1'b0;
        last_op = '0;
        last_m  = '0;
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            get_bits(1, r);
            if (r[0])
            begin
                @(negedge clk);
                check_prev(had, last_op, last_m);
                insn_valid = 1'b0;
                had        = 1'b0;
            end
            get_bits(8, r);
            op = r[7:0];
            get_bits(8, r);
            m  = r[7:0];
            @(negedge clk);
            check_prev(had, last_op, last_m);
            insn_valid = 1'b1;
            opcode     = op;
            modrm      = m;
            had        = 1'b1;
            last_op    = op;
            last_m     = m;
        end
        @(negedge clk);
        check_prev(had, last_op, last_m);
        insn_valid = 1'b0;
        @(negedge clk);
        check_prev(1'b0, last_op, last_m);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        errors     = 0;
        checks     = 0;
        lfsr       = 32'hbf9f_c4a1;
        reset      = 1'b1;
        insn_valid = 1'b1;      // Strobe held through reset
        opcode     = 8'h8b;     // Nonzero pair must not leak through reset
        modrm      = 8'h46;
        check_idle(5);
        reset      = 1'b0;
        insn_valid = 1'b0;
        check_idle(3);
        test_alu_regs();
        test_ea_modes();
        test_immediates();
        test_special();
        test_stream();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- instr_decoder.f
src/x86_isa_pkg.sv
src/decode_pkg.sv
src/ea_decode.sv
src/opcode_decode.sv
src/instr_decoder.sv
testbench/instr_decoder_asserts.sv
testbench/tb_instr_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the instr_decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
FAIL_MSG="Checks failed"

verilator --binary --assert --top-module tb_instr_decoder \
    --Mdir "$BUILD_DIR" -o tb_sim -f instr_decoder.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

# A failed assertion stops the simulator with a nonzero status
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
